//--- rtl/dbg_macros.svh
// -------------------------------------------------------------------------
// Debug subsystem sizes, address map, delay count and ROM fill pattern
// -------------------------------------------------------------------------

`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

// Debug access port widths
`define DBG_DATA_W      32
`define DBG_ADDR_W      7

// Word index width carried on a memory bus
`define DBG_MEM_AW      5

// Address map in words
`define DBG_ROM_BASE    7'h00
`define DBG_ROM_WORDS   16
`define DBG_CTRL_ADDR   7'h10
`define DBG_RAM_BASE    7'h20
`define DBG_RAM_WORDS   32

// Cycles after system reset release before a halt request may pass
`define DBG_DEL_CYCLES  20

// Upper half of every boot ROM word
`define DBG_ROM_TAG     16'hB007

`endif

//--- rtl/dbg_pkg.sv
// -------------------------------------------------------------------------
// Shared types of the debug subsystem
// -------------------------------------------------------------------------

package dbg_pkg;

  // Operation requested on the debug access port
  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2
  } dmi_op_e;

  // Access response
  typedef enum logic {
    RESP_OK  = 1'b0,
    RESP_ERR = 1'b1
  } dmi_resp_e;

  // Access controller FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_RESP
  } ctrl_state_e;

  // Decoded target of an access
  typedef enum logic [1:0] {
    REG_ROM,
    REG_CTRL,
    REG_RAM,
    REG_NONE
  } region_e;

endpackage

//--- rtl/mem_if.sv
// -------------------------------------------------------------------------
// Single word access from the controller to one memory
// -------------------------------------------------------------------------

`timescale 1ns/1ns

`include "dbg_macros.svh"

interface mem_if;

  // One-cycle request that also times a write
  logic                   req;
  logic                   we;
  // Region-relative word index
  logic [`DBG_MEM_AW-1:0] addr;
  logic [`DBG_DATA_W-1:0] wdata;
  // Valid the cycle after req, held until the next req
  logic [`DBG_DATA_W-1:0] rdata;

  modport ctrl (output req, we, addr, wdata, input rdata);

  modport mem (input req, we, addr, wdata, output rdata);

endinterface

//--- rtl/boot_rom.sv
// -------------------------------------------------------------------------
// Boot ROM with a fixed tagged fill and a registered read
// -------------------------------------------------------------------------

`timescale 1ns/1ns

`include "dbg_macros.svh"

module boot_rom (
  input logic clk_i,
  mem_if.mem  bus
);

  localparam int unsigned rom_aw = $clog2(`DBG_ROM_WORDS);

  logic [`DBG_DATA_W-1:0] rom_table [`DBG_ROM_WORDS];
  logic [`DBG_DATA_W-1:0] rdata_q;

  // Word i reads as the tag over its own index
  for (genvar i = 0; i < `DBG_ROM_WORDS; i++) begin : g_fill
    assign rom_table[i] = {`DBG_ROM_TAG, 16'(i)};
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= rom_table[bus.addr[rom_aw-1:0]];
    end
  end

  assign bus.rdata = rdata_q;

endmodule

//--- rtl/sys_sram.sv
// -------------------------------------------------------------------------
// System SRAM of whole words with a registered read
// -------------------------------------------------------------------------

`timescale 1ns/1ns

`include "dbg_macros.svh"

module sys_sram (
  input logic clk_i,
  mem_if.mem  bus
);

  localparam int unsigned ram_aw = $clog2(`DBG_RAM_WORDS);

  logic [`DBG_DATA_W-1:0] mem_q [`DBG_RAM_WORDS];
  logic [`DBG_DATA_W-1:0] rdata_q;

  // One write or one registered read per request
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        mem_q[bus.addr[ram_aw-1:0]] <= bus.wdata;
      end else begin
        rdata_q <= mem_q[bus.addr[ram_aw-1:0]];
      end
    end
  end

  // Read data holds across writes until the next read
  assign bus.rdata = rdata_q;

endmodule

//--- rtl/reset_ctrl.sv
// -------------------------------------------------------------------------
// Control register and system reset synchronizer driven by ndmreset
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module reset_ctrl (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       ctrl_we_i,
  input  logic [1:0] ctrl_wdata_i,
  output logic [1:0] ctrl_rdata_o,
  output logic       ndmreset_o,
  output logic       haltreq_o,
  output logic       sys_rst_no
);

  logic [1:0] ctrl_q;
  logic       sync_rst_n;
  logic [1:0] sync_q;

  // Bit 0 ndmreset, bit 1 haltreq
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else if (ctrl_we_i) begin
      ctrl_q <= ctrl_wdata_i;
    end
  end

  assign ctrl_rdata_o = ctrl_q;
  assign ndmreset_o   = ctrl_q[0];
  assign haltreq_o    = ctrl_q[1];

  // Asserts at once, releases two edges after both sources clear
  assign sync_rst_n = rst_ni & ~ctrl_q[0];

  always_ff @(posedge clk_i or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

  // System stays in reset through ndmreset and the two release edges
  a_ndm_holds_sys_rst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ndmreset_o |-> !sys_rst_no ##1 !sys_rst_no ##1 !sys_rst_no);

endmodule

//--- rtl/req_delay_timer.sv
// -------------------------------------------------------------------------
// Holds the debug request low for a fixed time after system reset release
// -------------------------------------------------------------------------

`timescale 1ns/1ns

`include "dbg_macros.svh"

module req_delay_timer (
  input  logic clk_i,
  input  logic sys_rst_ni,
  input  logic haltreq_i,
  output logic debug_req_o
);

  localparam int unsigned cnt_w = $clog2(`DBG_DEL_CYCLES + 1);

  logic [cnt_w-1:0] cnt_q;

  // Reloaded for as long as the system is in reset
  always_ff @(posedge clk_i or negedge sys_rst_ni) begin
    if (!sys_rst_ni) begin
      cnt_q <= cnt_w'(`DBG_DEL_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Boot code gets its window before a halt can interrupt it
  assign debug_req_o = (cnt_q == '0) && haltreq_i;

  // A request implies the system has been out of reset for the full delay
  a_req_after_delay: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    debug_req_o |-> (cnt_q == '0) && $past(sys_rst_ni, `DBG_DEL_CYCLES));

endmodule

//--- rtl/dmi_ctrl.sv
// -------------------------------------------------------------------------
// Debug access controller with four-phase handshake and region decode,
// steering each access to the boot ROM, the SRAM or the control register
// -------------------------------------------------------------------------

`timescale 1ns/1ns

`include "dbg_macros.svh"

module dmi_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   dmi_req_i,
  input  dbg_pkg::dmi_op_e       dmi_op_i,
  input  logic [`DBG_ADDR_W-1:0] dmi_addr_i,
  input  logic [`DBG_DATA_W-1:0] dmi_wdata_i,
  output logic                   dmi_ack_o,
  output logic [`DBG_DATA_W-1:0] dmi_rdata_o,
  output dbg_pkg::dmi_resp_e     dmi_resp_o,
  output logic                   ctrl_we_o,
  output logic [1:0]             ctrl_wdata_o,
  input  logic [1:0]             ctrl_rdata_i,
  mem_if.ctrl                    rom_bus,
  mem_if.ctrl                    ram_bus
);

  dbg_pkg::ctrl_state_e   state_d, state_q;
  dbg_pkg::dmi_op_e       op_q;
  dbg_pkg::region_e       region_d, region_q;
  logic                   err_d, err_q;
  logic                   accept;
  logic [`DBG_ADDR_W-1:0] rom_off, ram_off;
  logic [`DBG_MEM_AW-1:0] mem_addr_d, mem_addr_q;
  logic [`DBG_DATA_W-1:0] wdata_q;
  logic                   mem_go, mem_we;

  // -------------------------------------------------------------------------
  // Address decode
  // -------------------------------------------------------------------------
  // Offsets wrap for addresses below a base and then fall out of range
  assign rom_off = dmi_addr_i - `DBG_ROM_BASE;
  assign ram_off = dmi_addr_i - `DBG_RAM_BASE;

  always_comb begin
    if (rom_off < `DBG_ROM_WORDS) begin
      region_d = dbg_pkg::REG_ROM;
    end else if (dmi_addr_i == `DBG_CTRL_ADDR) begin
      region_d = dbg_pkg::REG_CTRL;
    end else if (ram_off < `DBG_RAM_WORDS) begin
      region_d = dbg_pkg::REG_RAM;
    end else begin
      region_d = dbg_pkg::REG_NONE;
    end
  end

  assign mem_addr_d = (region_d == dbg_pkg::REG_RAM) ? ram_off[`DBG_MEM_AW-1:0]
                                                     : rom_off[`DBG_MEM_AW-1:0];

  // A NOP never fails; unmapped space and ROM writes do
  assign err_d = (dmi_op_i != dbg_pkg::DMI_NOP) &&
                 ((region_d == dbg_pkg::REG_NONE) ||
                  (region_d == dbg_pkg::REG_ROM && dmi_op_i == dbg_pkg::DMI_WRITE));

  // -------------------------------------------------------------------------
  // Handshake FSM
  // -------------------------------------------------------------------------
  assign accept = (state_q == dbg_pkg::ST_IDLE) && dmi_req_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      dbg_pkg::ST_IDLE:   if (dmi_req_i) state_d = dbg_pkg::ST_ACCESS;
      dbg_pkg::ST_ACCESS: state_d = dbg_pkg::ST_RESP;
      // Hold the response until the requester lets go
      dbg_pkg::ST_RESP:   if (!dmi_req_i) state_d = dbg_pkg::ST_IDLE;
      default:            state_d = dbg_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= dbg_pkg::ST_IDLE;
      op_q     <= dbg_pkg::DMI_NOP;
      region_q <= dbg_pkg::REG_NONE;
      err_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        op_q     <= dmi_op_i;
        region_q <= region_d;
        err_q    <= err_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_addr_q <= mem_addr_d;
      wdata_q    <= dmi_wdata_i;
    end
  end

  // -------------------------------------------------------------------------
  // Access steering
  // -------------------------------------------------------------------------
  assign mem_go = (state_q == dbg_pkg::ST_ACCESS) && (op_q != dbg_pkg::DMI_NOP) && !err_q;
  assign mem_we = (op_q == dbg_pkg::DMI_WRITE) && !err_q;

  assign rom_bus.req   = mem_go && (region_q == dbg_pkg::REG_ROM);
  assign rom_bus.we    = mem_we && (region_q == dbg_pkg::REG_ROM);
  assign rom_bus.addr  = mem_addr_q;
  assign rom_bus.wdata = wdata_q;

  assign ram_bus.req   = mem_go && (region_q == dbg_pkg::REG_RAM);
  assign ram_bus.we    = mem_we && (region_q == dbg_pkg::REG_RAM);
  assign ram_bus.addr  = mem_addr_q;
  assign ram_bus.wdata = wdata_q;

  assign ctrl_we_o    = mem_go && mem_we && (region_q == dbg_pkg::REG_CTRL);
  assign ctrl_wdata_o = wdata_q[1:0];

  // Only reads of a good access carry data
  assign dmi_ack_o  = (state_q == dbg_pkg::ST_RESP);
  assign dmi_resp_o = err_q ? dbg_pkg::RESP_ERR : dbg_pkg::RESP_OK;

  always_comb begin
    dmi_rdata_o = '0;
    if (dmi_ack_o && op_q == dbg_pkg::DMI_READ && !err_q) begin
      case (region_q)
        dbg_pkg::REG_ROM:  dmi_rdata_o = rom_bus.rdata;
        dbg_pkg::REG_RAM:  dmi_rdata_o = ram_bus.rdata;
        dbg_pkg::REG_CTRL: dmi_rdata_o = {{(`DBG_DATA_W-2){1'b0}}, ctrl_rdata_i};
        default:           dmi_rdata_o = '0;
      endcase
    end
  end

  // Ack only comes up after an access cycle of a request that was held
  a_ack_after_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(dmi_ack_o) |-> $past(state_q == dbg_pkg::ST_ACCESS) && $past(dmi_req_i, 2));

  a_one_mem_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rom_bus.req && ram_bus.req));

  // The boot ROM never sees a write strobe
  a_rom_no_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rom_bus.we);

endmodule

//--- rtl/dbg_harness_top.sv
// -------------------------------------------------------------------------
// Debug subsystem top with access port, memories, control register and
// the gated debug request
// -------------------------------------------------------------------------

`timescale 1ns/1ns

`include "dbg_macros.svh"

module dbg_harness_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   dmi_req_i,
  input  logic [1:0]             dmi_op_i,
  input  logic [`DBG_ADDR_W-1:0] dmi_addr_i,
  input  logic [`DBG_DATA_W-1:0] dmi_wdata_i,
  output logic                   dmi_ack_o,
  output logic [`DBG_DATA_W-1:0] dmi_rdata_o,
  output logic                   dmi_resp_o,
  output logic                   debug_req_o,
  output logic                   ndmreset_o
);

  dbg_pkg::dmi_op_e   dmi_op;
  dbg_pkg::dmi_resp_e dmi_resp;
  logic               ctrl_we;
  logic [1:0]         ctrl_wdata;
  logic [1:0]         ctrl_rdata;
  logic               haltreq;
  logic               sys_rst_n;

  assign dmi_op     = dbg_pkg::dmi_op_e'(dmi_op_i);
  assign dmi_resp_o = dmi_resp;

  mem_if rom_bus ();
  mem_if ram_bus ();

  // Controller runs on power-on reset so it stays usable during ndmreset
  dmi_ctrl dmi_ctrl_i (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .dmi_req_i    ( dmi_req_i   ),
    .dmi_op_i     ( dmi_op      ),
    .dmi_addr_i   ( dmi_addr_i  ),
    .dmi_wdata_i  ( dmi_wdata_i ),
    .dmi_ack_o    ( dmi_ack_o   ),
    .dmi_rdata_o  ( dmi_rdata_o ),
    .dmi_resp_o   ( dmi_resp    ),
    .ctrl_we_o    ( ctrl_we     ),
    .ctrl_wdata_o ( ctrl_wdata  ),
    .ctrl_rdata_i ( ctrl_rdata  ),
    .rom_bus      ( rom_bus     ),
    .ram_bus      ( ram_bus     )
  );

  reset_ctrl reset_ctrl_i (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .ctrl_we_i    ( ctrl_we    ),
    .ctrl_wdata_i ( ctrl_wdata ),
    .ctrl_rdata_o ( ctrl_rdata ),
    .ndmreset_o   ( ndmreset_o ),
    .haltreq_o    ( haltreq    ),
    .sys_rst_no   ( sys_rst_n  )
  );

  req_delay_timer req_delay_timer_i (
    .clk_i       ( clk_i       ),
    .sys_rst_ni  ( sys_rst_n   ),
    .haltreq_i   ( haltreq     ),
    .debug_req_o ( debug_req_o )
  );

  boot_rom boot_rom_i (
    .clk_i ( clk_i   ),
    .bus   ( rom_bus )
  );

  sys_sram sys_sram_i (
    .clk_i ( clk_i   ),
    .bus   ( ram_bus )
  );

endmodule

//--- verif/tb_dbg_harness.sv
// -------------------------------------------------------------------------
// Testbench for the debug subsystem covering the access port handshake,
// memories, error responses, debug request gate and ndmreset
// -------------------------------------------------------------------------

`timescale 1ns/1ns

`include "dbg_macros.svh"

module tb_dbg_harness;

  localparam int unsigned clk_half     = 4;
  localparam int unsigned n_ram_writes = 24;
  // Upper bound on accesses over the whole run
  localparam int unsigned n_accesses   = 2 + `DBG_ROM_WORDS + n_ram_writes +
                                         2 * `DBG_RAM_WORDS + 8 + 4;
  localparam int unsigned timeout_cyc  = n_accesses * 10 + `DBG_DEL_CYCLES * 4 + 200;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   dmi_req_i;
  logic [1:0]             dmi_op_i;
  logic [`DBG_ADDR_W-1:0] dmi_addr_i;
  logic [`DBG_DATA_W-1:0] dmi_wdata_i;
  logic                   dmi_ack_o;
  logic [`DBG_DATA_W-1:0] dmi_rdata_o;
  logic                   dmi_resp_o;
  logic                   debug_req_o;
  logic                   ndmreset_o;

  // Reference copy of the SRAM and which words hold known data
  logic [`DBG_DATA_W-1:0] ram_model [`DBG_RAM_WORDS];
  logic                   ram_valid [`DBG_RAM_WORDS];
  // Cycles since the last release of power-on reset or ndmreset
  int unsigned            gate_cnt;

  dbg_harness_top dbg_harness_top_i (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .dmi_req_i   ( dmi_req_i   ),
    .dmi_op_i    ( dmi_op_i    ),
    .dmi_addr_i  ( dmi_addr_i  ),
    .dmi_wdata_i ( dmi_wdata_i ),
    .dmi_ack_o   ( dmi_ack_o   ),
    .dmi_rdata_o ( dmi_rdata_o ),
    .dmi_resp_o  ( dmi_resp_o  ),
    .debug_req_o ( debug_req_o ),
    .ndmreset_o  ( ndmreset_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_half) clk_i = ~clk_i;
  end

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  // -------------------------------------------------------------------------
  // Handshake and gate checks
  // -------------------------------------------------------------------------
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(dmi_ack_o) |-> dmi_req_i)
    else begin
      $display("Handshake error: ack rose while no request was pending");
      abort_run();
    end

  ack_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dmi_ack_o && dmi_req_i) |=>
      (dmi_ack_o && $stable(dmi_rdata_o) && $stable(dmi_resp_o)))
    else begin
      $display("Handshake error: ack or response changed while request was held");
      abort_run();
    end

  always @(negedge clk_i) begin
    if (!rst_ni || ndmreset_o) begin
      gate_cnt = 0;
    end else begin
      gate_cnt = gate_cnt + 1;
    end
    if (debug_req_o) begin
      assert (gate_cnt > `DBG_DEL_CYCLES) else begin
        $display("Debug request passed %0d cycles after reset release", gate_cnt);
        abort_run();
      end
    end
  end

  // Four-phase access with a random hold of req after ack
  task automatic dmi_access(input logic [1:0] op, input logic [6:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic resp);
    int unsigned hold;
    hold = $urandom_range(3, 0);
    @(posedge clk_i);
    #1;
    dmi_req_i   = 1'b1;
    dmi_op_i    = op;
    dmi_addr_i  = addr;
    dmi_wdata_i = wdata;
    do @(negedge clk_i); while (!dmi_ack_o);
    rdata = dmi_rdata_o;
    resp  = dmi_resp_o;
    repeat (hold) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    dmi_req_i = 1'b0;
    dmi_op_i  = dbg_pkg::DMI_NOP;
    do @(negedge clk_i); while (dmi_ack_o);
  endtask

  task automatic access_check(input logic [1:0] op, input logic [6:0] addr,
                              input logic [31:0] wdata, input logic [31:0] exp_data,
                              input logic exp_resp);
    logic [31:0] rdata;
    logic        resp;
    dmi_access(op, addr, wdata, rdata, resp);
    check_value($sformatf("dmi_rdata_o (addr %h)", addr), exp_data, rdata);
    check_value($sformatf("dmi_resp_o (addr %h)", addr), 32'(exp_resp), 32'(resp));
  endtask

  task automatic verify_ram();
    for (int i = 0; i < `DBG_RAM_WORDS; i++) begin
      if (ram_valid[i]) begin
        access_check(dbg_pkg::DMI_READ, 7'(`DBG_RAM_BASE + i), '0, ram_model[i],
                     dbg_pkg::RESP_OK);
      end
    end
  endtask

  task automatic wait_gate(input int unsigned cycles);
    do begin
      @(negedge clk_i);
      #1;
    end while (gate_cnt < cycles);
  endtask

  initial begin
    repeat (timeout_cyc) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", timeout_cyc);
    abort_run();
  end

  // -------------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------------
  initial begin
    int unsigned idx;
    logic [31:0] val;
    void'($urandom(32'h3b1b87b3));
    gate_cnt    = 0;
    rst_ni      = 1'b0;
    dmi_req_i   = 1'b0;
    dmi_op_i    = dbg_pkg::DMI_NOP;
    dmi_addr_i  = '0;
    dmi_wdata_i = '0;
    for (int i = 0; i < `DBG_RAM_WORDS; i++) begin
      ram_valid[i] = 1'b0;
    end
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("dmi_ack_o", 32'd0, 32'(dmi_ack_o));
    check_value("ndmreset_o", 32'd0, 32'(ndmreset_o));
    check_value("debug_req_o", 32'd0, 32'(debug_req_o));

    // Halt request passes only after the delay
    access_check(dbg_pkg::DMI_WRITE, `DBG_CTRL_ADDR, 32'h2, '0, dbg_pkg::RESP_OK);
    wait_gate(`DBG_DEL_CYCLES + 4);
    check_value("debug_req_o", 32'd1, 32'(debug_req_o));
    access_check(dbg_pkg::DMI_WRITE, `DBG_CTRL_ADDR, 32'h0, '0, dbg_pkg::RESP_OK);
    check_value("debug_req_o", 32'd0, 32'(debug_req_o));

    for (int i = 0; i < `DBG_ROM_WORDS; i++) begin
      access_check(dbg_pkg::DMI_READ, 7'(`DBG_ROM_BASE + i), '0,
                   {`DBG_ROM_TAG, 16'(i)}, dbg_pkg::RESP_OK);
    end

    for (int k = 0; k < n_ram_writes; k++) begin
      idx = $urandom_range(`DBG_RAM_WORDS - 1, 0);
      val = $urandom;
      access_check(dbg_pkg::DMI_WRITE, 7'(`DBG_RAM_BASE + idx), val, '0,
                   dbg_pkg::RESP_OK);
      ram_model[idx] = val;
      ram_valid[idx] = 1'b1;
    end
    verify_ram();

    // ROM writes and unmapped space fail without side effects
    access_check(dbg_pkg::DMI_WRITE, 7'(`DBG_ROM_BASE + 5), 32'hDEAD_BEEF, '0,
                 dbg_pkg::RESP_ERR);
    access_check(dbg_pkg::DMI_READ, 7'h11, '0, '0, dbg_pkg::RESP_ERR);
    access_check(dbg_pkg::DMI_READ, 7'h1F, '0, '0, dbg_pkg::RESP_ERR);
    access_check(dbg_pkg::DMI_WRITE, 7'h40, 32'h1234_5678, '0, dbg_pkg::RESP_ERR);
    access_check(dbg_pkg::DMI_READ, 7'h7F, '0, '0, dbg_pkg::RESP_ERR);
    access_check(dbg_pkg::DMI_READ, 7'(`DBG_ROM_BASE + 5), '0,
                 {`DBG_ROM_TAG, 16'd5}, dbg_pkg::RESP_OK);
    access_check(dbg_pkg::DMI_NOP, 7'h50, 32'hFFFF_FFFF, '0, dbg_pkg::RESP_OK);

    // ndmreset with a pending halt request
    access_check(dbg_pkg::DMI_WRITE, `DBG_CTRL_ADDR, 32'h3, '0, dbg_pkg::RESP_OK);
    check_value("ndmreset_o", 32'd1, 32'(ndmreset_o));
    access_check(dbg_pkg::DMI_READ, `DBG_CTRL_ADDR, '0, 32'h3, dbg_pkg::RESP_OK);
    check_value("debug_req_o", 32'd0, 32'(debug_req_o));
    access_check(dbg_pkg::DMI_WRITE, `DBG_CTRL_ADDR, 32'h2, '0, dbg_pkg::RESP_OK);
    check_value("ndmreset_o", 32'd0, 32'(ndmreset_o));
    wait_gate(`DBG_DEL_CYCLES + 4);
    check_value("debug_req_o", 32'd1, 32'(debug_req_o));
    verify_ram();

    $display("** PASS **");
    $finish;
  end

endmodule

//--- sim.f
+incdir+rtl
rtl/dbg_pkg.sv
rtl/mem_if.sv
rtl/boot_rom.sv
rtl/sys_sram.sv
rtl/reset_ctrl.sv
rtl/req_delay_timer.sv
rtl/dmi_ctrl.sv
rtl/dbg_harness_top.sv
verif/tb_dbg_harness.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the debug subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f \
  --top-module tb_dbg_harness \
  -o tb_dbg_harness

./obj_dir/tb_dbg_harness | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
